// File: commitAgg/commitAgg.sv
// Aggregation table matching per-TPU commits to outstanding issues
// Head retires once every enabled lane has committed, strictly in order
// Commits carrying a number that is not outstanding are dropped
// Caller guarantees no write into an occupied slot

module commitAgg (
	input  logic               clock,
	input  logic               reset,
	input  aggPkg::issue_t     issue,
	input  aggPkg::tpuCommit_t tpuCommit,
	input  mpuPkg::ringPtr_t   wrPtr,
	input  mpuPkg::ringPtr_t   rdPtr,
	output logic               retire,
	output aggPkg::commit_t    commit
);

	import mpuPkg::*;
	import aggPkg::*;

	aggEntry_t aggTable [BUFF_SIZE-1:0];
	tpuMask_t  laneHit  [BUFF_SIZE-1:0];   // Lanes committing to each slot this cycle
	aggEntry_t headEntry;

	//////////////////////////////
	// Commit matching
	//////////////////////////////

	// A lane hits a slot only if the slot is live and expects that lane
	always_comb begin
		for (int i = 0; i < BUFF_SIZE; i++) begin
			for (int j = 0; j < NUM_TPU; j++) begin
				laneHit[i][j] = aggTable[i].valid
					& aggTable[i].enMask[j]
					& tpuCommit.req[j]
					& (tpuCommit.no[j] == aggTable[i].no);
			end
		end
	end

	//////////////////////////////
	// Head release
	//////////////////////////////

	assign headEntry = aggTable[rdPtr];

	// Empty enable mask compares equal at once
	assign retire = headEntry.valid & (headEntry.cmtMask == headEntry.enMask);

	assign commit = '{req: retire, no: headEntry.no};

	//////////////////////////////
	// Table update
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < BUFF_SIZE; i++) begin
				aggTable[i].valid <= 1'b0;
			end
		end else begin
			// Accumulate lane commits on every slot
			for (int i = 0; i < BUFF_SIZE; i++) begin
				aggTable[i].cmtMask <= aggTable[i].cmtMask | laneHit[i];
			end

			if (retire)
				aggTable[rdPtr].valid <= 1'b0;   // Frees the head slot

			// New issue lands at the tail, never the retiring head
			if (issue.valid) begin
				aggTable[wrPtr] <= '{
					valid:   1'b1,
					enMask:  issue.enMask,
					cmtMask: '0,
					no:      issue.no
				};
			end
		end
	end

endmodule

// File: commitAgg/ringBuffCtrl.sv
// Pointer and occupancy control for a ring of numEntry slots
// numEntry must be a power of two, pointers wrap by truncation
// No protection against we when full or re when empty

module ringBuffCtrl #(
	parameter int numEntry = 4,
	localparam int ptrW = $clog2(numEntry),
	localparam int cntW = $clog2(numEntry + 1)
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            we,
	input  logic            re,
	output logic [ptrW-1:0] wrPtr,
	output logic [ptrW-1:0] rdPtr,
	output logic            full,
	output logic            almostFull,
	output logic            empty
);

	logic [cntW-1:0] count;   // Occupied slots

	//////////////////////////////
	// Pointers and count
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (we)
				wrPtr <= wrPtr + ptrW'(1);
			if (re)
				rdPtr <= rdPtr + ptrW'(1);

			// Simultaneous read and write keeps the count
			case ({we, re})
				2'b10:   count <= count + cntW'(1);
				2'b01:   count <= count - cntW'(1);
				default: count <= count;
			endcase
		end
	end

	//////////////////////////////
	// Flags
	//////////////////////////////

	assign full       = (count == cntW'(numEntry));
	assign almostFull = (count == cntW'(numEntry - 1));  // One slot left
	assign empty      = (count == '0);

endmodule

// File: commitUnit.f
common/mpuPkg.sv
common/aggPkg.sv
commitAgg/ringBuffCtrl.sv
commitAgg/commitAgg.sv
logic/issueGate.sv
logic/commitUnit.sv
dv/clockGen.sv
dv/commitUnit_asserts.sv
dv/commitUnitTb.sv

// File: common/aggPkg.sv
// Bundles exchanged between issue gate, aggregation table and TPUs
// Commit tags are only meaningful on lanes whose req bit is set

package aggPkg;

	import mpuPkg::*;

	//////////////////////////////
	// Issue side
	//////////////////////////////

	// Registered issue toward the aggregation table, 9 bits
	typedef struct packed {
		logic     valid;
		tpuMask_t enMask;   // Lanes taking part
		issueNo_t no;
	} issue_t;

	//////////////////////////////
	// TPU side
	//////////////////////////////

	// Per-lane commit strobes with their tags, 20 bits
	typedef struct packed {
		tpuMask_t                 req;
		issueNo_t [NUM_TPU-1:0] no;    // Lane j tag at no[j]
	} tpuCommit_t;

	// One aggregation slot, 13 bits
	typedef struct packed {
		logic     valid;
		tpuMask_t enMask;
		tpuMask_t cmtMask;  // Lanes already committed
		issueNo_t no;
	} aggEntry_t;

	// In-order completion report to the issuer, 5 bits
	typedef struct packed {
		logic     req;
		issueNo_t no;
	} commit_t;

endpackage

// File: common/mpuPkg.sv
// Issue-side constants and types for the commit stage
// BUFF_SIZE must stay a power of two and well below 2**ISSUE_W
// so that outstanding issue numbers never alias

package mpuPkg;

	//////////////////////////////
	// Sizing
	//////////////////////////////

	localparam int NUM_TPU   = 4;                  // TPU lanes per group
	localparam int BUFF_SIZE = 4;                  // Outstanding instructions
	localparam int ISSUE_W   = 4;                  // Issue number bits, wraps at 16
	localparam int PTR_W     = $clog2(BUFF_SIZE);

	//////////////////////////////
	// Types
	//////////////////////////////

	// Issue number, compared against TPU commit tags
	typedef logic [ISSUE_W-1:0] issueNo_t;

	// One bit per TPU lane
	typedef logic [NUM_TPU-1:0] tpuMask_t;

	// Index into the aggregation ring
	typedef logic [PTR_W-1:0] ringPtr_t;

endpackage

// File: dv/clockGen.sv
// Testbench clock and reset source
// Reset is synchronous high, held over the first two rising edges
// and released on a falling edge

module clockGen #(
	parameter int halfPeriod  = 5,
	parameter int resetCycles = 2
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #halfPeriod clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;   // Inputs change on falling edges only
	end

endmodule

// File: dv/commitUnitTb.sv
// Replays per-cycle vectors from dv/commitUnit_stimulus.txt on the commit unit
// Must run from the project root so the stimulus path resolves
// Rows drive on a falling edge and are checked at the next falling edge
// commit.no is compared only on rows that expect commit.req

module commitUnitTb;

	import mpuPkg::*;
	import aggPkg::*;

	localparam int clockPeriod = 10;
	localparam int maxRows     = 256;
	localparam int rowW        = 52;

	// One stimulus row, hex nibbles in file order
	typedef struct packed {
		logic [7:0]             testId;
		logic [3:0]             issueReq;
		tpuMask_t               issueMask;
		tpuMask_t               cmtReq;
		issueNo_t [NUM_TPU-1:0] cmtNo;      // Lane 3 first
		logic [3:0]             expReq;
		issueNo_t               expNo;
		logic [3:0]             expStall;
		issueNo_t               expIssueNo;
	} stimRow_t;

	logic       clock;
	logic       reset;
	logic       issueReq;
	tpuMask_t   issueMask;
	tpuCommit_t tpuCommit;
	issueNo_t   issueNo;
	logic       issueStall;
	commit_t    commit;

	logic [rowW-1:0] stimMem [maxRows];
	int              rowCount   = 0;
	int              errorCount = 0;
	int              checkCount = 0;
	bit              loaded     = 1'b0;

	clockGen clockGen0 (
		.clock (clock),
		.reset (reset)
	);

	commitUnit dut0 (
		.clock      (clock),
		.reset      (reset),
		.issueReq   (issueReq),
		.issueMask  (issueMask),
		.tpuCommit  (tpuCommit),
		.issueNo    (issueNo),
		.issueStall (issueStall),
		.commit     (commit)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic string testLabel(input logic [7:0] id);
		case (id)
			8'h01:   return "reverseLanes";
			8'h02:   return "partialMask";
			8'h03:   return "inOrderRelease";
			8'h04:   return "emptyMask";
			8'h05:   return "ringFull";
			8'h06:   return "numberWrap";
			default: return "unknownTest";
		endcase
	endfunction

	task automatic compareValue(input string testName, input string what,
		input int expected, input int actual);
		checkCount++;
		if (expected != actual) begin
			errorCount++;
			$display("Mismatch in %s, %s: expected %0h, actual %0h",
				testName, what, expected, actual);
		end
	endtask

	task automatic applyRow(input stimRow_t row);
		issueReq      = row.issueReq[0];
		issueMask     = row.issueMask;
		tpuCommit.req = row.cmtReq;
		tpuCommit.no  = row.cmtNo;
	endtask

	task automatic checkRow(input int index, input stimRow_t row);
		string label;
		label = $sformatf("%s row %0d", testLabel(row.testId), index);
		compareValue(label, "commit.req", int'(row.expReq[0]), int'(commit.req));
		if (row.expReq[0])
			compareValue(label, "commit.no", int'(row.expNo), int'(commit.no));
		compareValue(label, "issueStall", int'(row.expStall[0]), int'(issueStall));
		compareValue(label, "issueNo", int'(row.expIssueNo), int'(issueNo));
	endtask

	//////////////////////////////
	// Stimulus and checking
	//////////////////////////////

	initial begin : stimulus
		stimRow_t row;
		int       assertFails;

		issueReq  = 1'b0;
		issueMask = '0;
		tpuCommit = '0;

		for (int i = 0; i < maxRows; i++)
			stimMem[i] = {8'hff, 44'(i)};   // Id ff marks rows past the file end
		$readmemh("dv/commitUnit_stimulus.txt", stimMem);
		while (rowCount < maxRows && stimMem[rowCount][rowW-1 -: 8] != 8'hff)
			rowCount++;
		loaded = 1'b1;
		if (rowCount == 0) begin
			errorCount++;
			$display("No stimulus rows could be loaded from the stimulus file");
		end

		@(negedge reset);
		for (int i = 0; i < rowCount; i++) begin
			row = stimRow_t'(stimMem[i]);
			applyRow(row);
			@(negedge clock);   // Outputs settled after the sampling edge
			checkRow(i, row);
		end

		assertFails = dut0.commitChecks0.failCount;
		$display("Rows %0d, checks %0d, mismatches %0d, assertion failures %0d",
			rowCount, checkCount, errorCount, assertFails);
		if (errorCount == 0 && assertFails == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Run length follows the row count plus margin for reset
	initial begin : watchdog
		wait (loaded);
		#((rowCount + 20) * clockPeriod);
		$display("Timeout: the run did not finish %0d stimulus rows in time", rowCount);
		$display("Regression failed");
		$finish;
	end

endmodule

// File: dv/commitUnit_asserts.sv
// Ordering and ring traffic checks on the commit unit, bound to each commitUnit
// Commit order assumes numbers are issued without gaps

module commitUnitAsserts (
	input logic            clock,
	input logic            reset,
	input aggPkg::issue_t  issue,
	input aggPkg::commit_t commit,
	input logic            full,
	input logic            empty
);

	import mpuPkg::*;

	int       repeatFails = 0;
	int       orderFails  = 0;
	int       flagFails   = 0;
	int       failCount;
	logic     haveLast;   // A commit was seen since reset
	issueNo_t lastNo;

	assign failCount = repeatFails + orderFails + flagFails;

	always_ff @(posedge clock) begin
		if (reset) begin
			haveLast <= 1'b0;
			lastNo   <= '0;
		end else if (commit.req) begin
			haveLast <= 1'b1;
			lastNo   <= commit.no;
		end
	end

	// Head slot clears on the edge that retires it
	repeatCheck: assert property (@(posedge clock) disable iff (reset)
		commit.req |=> !(commit.req && commit.no == $past(commit.no)))
	else begin
		repeatFails++;
		$error("commit.req held a second cycle for number %0h", commit.no);
	end

	orderCheck: assert property (@(posedge clock) disable iff (reset)
		(commit.req && haveLast) |-> commit.no == issueNo_t'(lastNo + 1'b1))
	else begin
		orderFails++;
		$error("Commit number %0h does not follow %0h", commit.no, lastNo);
	end

	// Gate holds back the last slot, table only retires live entries
	flagCheck: assert property (@(posedge clock) disable iff (reset)
		!(full && issue.valid) && !(empty && commit.req))
	else begin
		flagFails++;
		$error("Ring written while full or retired while empty");
	end

endmodule

bind commitUnit commitUnitAsserts commitChecks0 (
	.clock  (clock),
	.reset  (reset),
	.issue  (issue),
	.commit (commit),
	.full   (full),
	.empty  (empty)
);

// File: dv/commitUnit_stimulus.txt
// id_req_mask_cmtLanes_tags(lane3 lane2 lane1 lane0)_expReq_expNo_expStall_expIssueNo
// One row per cycle, expected values seen after the edge that samples the row
// Test 1 all four lanes, commits in reverse lane order
01_1_f_0_0000_0_0_0_1
01_0_0_0_0000_0_0_0_1
01_0_0_8_0000_0_0_0_1
01_0_0_4_0000_0_0_0_1
01_0_0_2_0000_0_0_0_1
01_0_0_1_0000_1_0_0_1
01_0_0_0_0000_0_0_0_1
// Test 2 lanes 0 and 2 enabled, lanes 1 and 3 commit the same number
02_1_5_0_0000_0_0_0_2
02_0_0_0_0000_0_0_0_2
02_0_0_a_1010_0_0_0_2
02_0_0_4_0100_0_0_0_2
02_0_0_9_1001_1_1_0_2
02_0_0_0_0000_0_0_0_2
// Test 3 second issue completes first, both released in order
03_1_3_0_0000_0_0_0_3
03_1_c_0_0000_0_0_0_4
03_0_0_0_0000_0_0_0_4
03_0_0_c_3300_0_0_0_4
03_0_0_1_0002_0_0_0_4
03_0_0_2_0020_1_2_0_4
03_0_0_0_0000_1_3_0_4
03_0_0_0_0000_0_0_0_4
// Test 4 empty mask
04_1_0_0_0000_0_0_0_5
04_0_0_0_0000_1_4_0_5
04_0_0_0_0000_0_0_0_5
// Test 5 fill the ring, extra requests dropped until a slot frees
05_1_1_0_0000_0_0_0_6
05_1_1_0_0000_0_0_0_7
05_1_1_0_0000_0_0_0_8
05_1_1_0_0000_0_0_0_9
05_1_1_0_0000_0_0_1_9
05_1_1_0_0000_0_0_1_9
05_1_1_1_0005_1_5_1_9
05_1_1_0_0000_0_0_0_9
05_1_1_0_0000_0_0_0_a
05_0_0_1_0006_1_6_1_a
05_0_0_1_0007_1_7_0_a
05_0_0_1_0008_1_8_0_a
05_0_0_1_0009_1_9_0_a
05_0_0_0_0000_0_0_0_a
// Test 6 back to back issues through the wrap from 15 to 0
06_1_3_0_0000_0_0_0_b
06_1_3_0_0000_0_0_0_c
06_1_3_3_00aa_1_a_0_d
06_1_3_3_00bb_1_b_0_e
06_1_3_3_00cc_1_c_0_f
06_1_3_3_00dd_1_d_0_0
06_1_3_3_00ee_1_e_0_1
06_1_3_3_00ff_1_f_0_2
06_0_0_3_0000_1_0_0_2
06_0_0_3_0011_1_1_0_2
06_0_0_0_0000_0_0_0_2
06_0_0_0_0000_0_0_0_2

// File: logic/commitUnit.sv
// Commit aggregation stage top level
// issueStall mirrors ring full, a request seen while high is lost
// tpuCommit strobes are single cycle and carry no back-pressure

module commitUnit (
	input  logic               clock,
	input  logic               reset,
	input  logic               issueReq,
	input  mpuPkg::tpuMask_t   issueMask,
	input  aggPkg::tpuCommit_t tpuCommit,
	output mpuPkg::issueNo_t   issueNo,
	output logic               issueStall,
	output aggPkg::commit_t    commit
);

	import mpuPkg::*;
	import aggPkg::*;

	issue_t   issue;        // Registered issue, doubles as ring write strobe
	ringPtr_t wrPtr;
	ringPtr_t rdPtr;
	logic     retire;
	logic     full;
	logic     almostFull;
	logic     empty;        // Observed by the bound checks

	assign issueStall = full;

	issueGate issueGate0 (
		.clock      (clock),
		.reset      (reset),
		.issueReq   (issueReq),
		.issueMask  (issueMask),
		.full       (full),
		.almostFull (almostFull),
		.issueNo    (issueNo),
		.issue      (issue)
	);

	commitAgg commitAgg0 (
		.clock     (clock),
		.reset     (reset),
		.issue     (issue),
		.tpuCommit (tpuCommit),
		.wrPtr     (wrPtr),
		.rdPtr     (rdPtr),
		.retire    (retire),
		.commit    (commit)
	);

	ringBuffCtrl #(
		.numEntry (BUFF_SIZE)
	) ringBuffCtrl0 (
		.clock      (clock),
		.reset      (reset),
		.we         (issue.valid),
		.re         (retire),
		.wrPtr      (wrPtr),
		.rdPtr      (rdPtr),
		.full       (full),
		.almostFull (almostFull),
		.empty      (empty)
	);

endmodule

// File: logic/issueGate.sv
// Accepts issue strobes while the ring has room and numbers them
// A refused request is dropped, the issuer must retry
// At most one registered issue is in flight toward the table

module issueGate (
	input  logic             clock,
	input  logic             reset,
	input  logic             issueReq,
	input  mpuPkg::tpuMask_t issueMask,
	input  logic             full,
	input  logic             almostFull,
	output mpuPkg::issueNo_t issueNo,     // Number of the next accepted issue
	output aggPkg::issue_t   issue
);

	import mpuPkg::*;

	logic     accept;
	logic     pendValid;   // Registered issue waiting for its table write
	tpuMask_t pendMask;
	issueNo_t pendNo;

	// Last free slot is already spoken for while an issue is pending
	assign accept = issueReq & ~full & ~(almostFull & pendValid);

	always_ff @(posedge clock) begin
		if (reset) begin
			pendValid <= 1'b0;
			issueNo   <= '0;
		end else begin
			pendValid <= accept;
			if (accept)
				issueNo <= issueNo + issueNo_t'(1);   // Wraps past 15
		end
	end

	// Payload only, qualified by pendValid
	always_ff @(posedge clock) begin
		if (accept) begin
			pendMask <= issueMask;
			pendNo   <= issueNo;
		end
	end

	assign issue = '{valid: pendValid, enMask: pendMask, no: pendNo};

endmodule

// File: run.sh
#!/bin/sh
# Build the commit unit testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module commitUnitTb \
	-f commitUnit.f -Mdir obj_dir || { echo "Build failed"; exit 1; }

out=$(./obj_dir/VcommitUnitTb +verilator+error+limit+100 2>&1)
echo "$out"
echo "$out" | grep -qx "Regression passed" && echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
